// ==== Makefile ====
# Verilator build and run for the posit core testbench

VERILATOR ?= verilator
TOP       ?= tb_ppu_core_ops
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== extraction.sv ====
`timescale 1ns/1ns
`default_nettype none

module extraction
  import ppu_pkg::*;
(
  input  stage0_t stage_i,
  output stage1_t stage_o
);

  localparam int RUN_W = $clog2(N);

  logic nar1, nar2;
  logic zero1, zero2;
  logic zero_rule;

  // length of the regime run, first bit included
  function automatic logic [RUN_W-1:0] regime_run(input logic [N-2:0] body);
    logic [RUN_W-1:0] run;
    logic             open;
    run  = RUN_W'(1);
    open = 1'b1;
    for (int i = N - 3; i >= 0; i--) begin
      if (open && (body[i] == body[N-2])) begin
        run = run + RUN_W'(1);
      end else begin
        open = 1'b0;
      end
    end
    return run;
  endfunction

  function automatic fir_t decode(input posit_t p);
    posit_t                    mag;
    logic [N-2:0]              body;
    logic [N-2:0]              rem;
    logic [RUN_W-1:0]          run;
    logic signed [TE_BITS-1:0] k;
    fir_t                      f;
    mag  = p[N-1] ? -p : p;                 // work on the magnitude
    body = mag[N-2:0];
    run  = regime_run(body);
    k    = body[N-2] ? $signed({{(TE_BITS-RUN_W){1'b0}}, run}) - 1
                     : -$signed({{(TE_BITS-RUN_W){1'b0}}, run});
    rem  = (body << run) << 1;              // drop regime and terminator
    f.sign      = p[N-1];
    f.total_exp = (k <<< ES) + $signed({{(TE_BITS-ES){1'b0}}, rem[N-2 -: ES]});
    f.mant      = {1'b1, rem[N-2-ES -: MANT_SIZE-1]};
    if (p == POSIT_ZERO) begin
      // smallest exponent so zero always aligns below the other operand
      f.sign      = 1'b0;
      f.total_exp = {1'b1, {(TE_BITS-1){1'b0}}};
      f.mant      = '0;
    end
    return f;
  endfunction

  assign nar1  = (stage_i.p1 == POSIT_NAR);
  assign nar2  = (stage_i.p2 == POSIT_NAR);
  assign zero1 = (stage_i.p1 == POSIT_ZERO);
  assign zero2 = (stage_i.p2 == POSIT_ZERO);

  assign zero_rule = (stage_i.op == OP_MUL) ? (zero1 | zero2) : (zero1 & zero2);

  always_comb begin
    stage_o.op   = stage_i.op;
    stage_o.fir1 = decode(stage_i.p1);
    stage_o.fir2 = decode(stage_i.p2);
    stage_o.fir3 = decode(stage_i.p3);
    if (stage_i.op == OP_SUB) begin
      stage_o.fir2.sign = ~stage_o.fir2.sign;  // a - b as a + (-b)
    end
    stage_o.p_special.is_nar  = nar1 | nar2;
    stage_o.p_special.is_zero = ~(nar1 | nar2) & zero_rule;
  end

endmodule : extraction

`default_nettype wire

// ==== fir_ops.sv ====
`timescale 1ns/1ns
`default_nettype none

module fir_ops
  import ppu_pkg::*;
(
  input  operation_e  op_i,
  input  fir_t        fir1_i,
  input  fir_t        fir2_i,
  input  fir_t        fir3_i,    // carried for a later fused op
  output ops_result_t result_o
);

  localparam int W = RES_MANT + 2;  // integer, fraction, guard, sticky

  localparam logic [TE_BITS:0] SHIFT_MAX = (TE_BITS + 1)'(W);

  // ##############################
  // multiply path
  // ##############################
  logic [RES_MANT-1:0]     mul_mant;
  logic signed [TE_BITS:0] mul_exp;

  assign mul_mant = fir1_i.mant * fir2_i.mant;
  assign mul_exp  = {fir1_i.total_exp[TE_BITS-1], fir1_i.total_exp}
                  + {fir2_i.total_exp[TE_BITS-1], fir2_i.total_exp};

  // ##############################
  // add path
  // ##############################
  logic             first_big;
  fir_t             big;
  fir_t             lesser;
  logic [TE_BITS:0] exp_diff;
  logic [TE_BITS:0] shift_amt;
  logic [W-1:0]     big_al;
  logic [W-1:0]     small_al;
  logic [2*W-1:0]   small_ext;
  logic [W-1:0]     small_sh;
  logic [W-1:0]     sum;

  // larger magnitude first
  assign first_big = ($signed(fir1_i.total_exp) > $signed(fir2_i.total_exp)) ||
                     ((fir1_i.total_exp == fir2_i.total_exp) &&
                      (fir1_i.mant >= fir2_i.mant));

  assign big    = first_big ? fir1_i : fir2_i;
  assign lesser = first_big ? fir2_i : fir1_i;

  assign exp_diff  = {big.total_exp[TE_BITS-1], big.total_exp}
                   - {lesser.total_exp[TE_BITS-1], lesser.total_exp};
  assign shift_amt = (exp_diff > SHIFT_MAX) ? SHIFT_MAX : exp_diff;

  assign big_al   = {1'b0, big.mant, {(W-1-MANT_SIZE){1'b0}}};
  assign small_al = {1'b0, lesser.mant, {(W-1-MANT_SIZE){1'b0}}};

  assign small_ext = {small_al, {W{1'b0}}} >> shift_amt;
  // everything shifted out folds into the sticky position
  assign small_sh  = {small_ext[2*W-1:W+1], small_ext[W] | (|small_ext[W-1:0])};

  assign sum = (big.sign == lesser.sign) ? big_al + small_sh
                                         : big_al - small_sh;

  always_comb begin
    if (op_i == OP_MUL) begin
      result_o.sign      = fir1_i.sign ^ fir2_i.sign;
      result_o.total_exp = mul_exp;
      result_o.mant      = mul_mant;
      result_o.guard     = 1'b0;   // product is exact
      result_o.sticky    = 1'b0;
    end else begin
      // exact cancellation gives a zero mantissa, sign forced positive
      result_o.sign      = (sum == '0) ? 1'b0 : big.sign;
      result_o.total_exp = {big.total_exp[TE_BITS-1], big.total_exp};
      {result_o.mant, result_o.guard, result_o.sticky} = sum;
    end
  end

endmodule : fir_ops

`default_nettype wire

// ==== normalization.sv ====
`timescale 1ns/1ns
`default_nettype none

module normalization
  import ppu_pkg::*;
(
  input  stage2_t stage_i,
  output posit_t  posit_o
);

  localparam int W       = RES_MANT + 2;
  localparam int LEAD_W  = $clog2(W);
  localparam int ADJ_W   = TE_BITS + 3;
  localparam int K_W     = TE_BITS - ES;
  localparam int BUILD_W = 2 + ES + (W - 1) + N;  // regime seed, exp, fraction, pad

  localparam logic signed [ADJ_W-1:0] HIDDEN_POS = ADJ_W'(W - 2);
  localparam logic signed [ADJ_W-1:0] TE_MAX     = ADJ_W'((N - 2) << ES);
  localparam logic signed [ADJ_W-1:0] TE_MIN     = -TE_MAX;

  logic [W-1:0]              raw;
  logic [LEAD_W-1:0]         lead;
  logic [W-1:0]              norm;
  logic signed [ADJ_W-1:0]   te_adj;
  logic signed [TE_BITS-1:0] te_clip;
  logic [W-2:0]              frac;
  logic signed [K_W-1:0]     k;
  logic [ES-1:0]             e;
  logic [BUILD_W-1:0]        build;
  logic [N-2:0]              mag_trunc;
  logic                      guard;
  logic                      sticky;
  logic [N-2:0]              mag_rnd;
  posit_t                    posit_abs;
  posit_t                    rounded;

  assign raw = {stage_i.ops_result.mant, stage_i.ops_result.guard,
                stage_i.ops_result.sticky};

  // ##############################
  // leading one and exponent
  // ##############################
  always_comb begin
    lead = '0;
    for (int i = 0; i < W; i++) begin
      if (raw[i]) lead = LEAD_W'(i);
    end
  end

  assign norm   = raw << (W - 1 - lead);   // leading one to the top
  assign te_adj = $signed({{2{stage_i.ops_result.total_exp[TE_BITS]}},
                           stage_i.ops_result.total_exp})
                + $signed({{(ADJ_W-LEAD_W){1'b0}}, lead}) - HIDDEN_POS;

  // saturate to maxpos / minpos
  always_comb begin
    if (te_adj > TE_MAX) begin
      te_clip = TE_MAX[TE_BITS-1:0];
      frac    = '0;
    end else if (te_adj < TE_MIN) begin
      te_clip = TE_MIN[TE_BITS-1:0];
      frac    = '0;
    end else begin
      te_clip = te_adj[TE_BITS-1:0];
      frac    = norm[W-2:0];
    end
  end

  assign k = te_clip[TE_BITS-1:ES];
  assign e = te_clip[ES-1:0];

  // ##############################
  // regime build and rounding
  // ##############################
  always_comb begin
    if (!k[K_W-1]) begin
      build = $signed({2'b10, e, frac, {N{1'b0}}}) >>> k;  // k+1 ones, then 0
    end else begin
      build = {2'b01, e, frac, {N{1'b0}}} >> (~k);         // -k zeros, then 1
    end
  end

  assign mag_trunc = build[BUILD_W-1 -: N-1];
  assign guard     = build[BUILD_W-N];
  assign sticky    = |build[BUILD_W-N-1:0];

  // nearest even
  assign mag_rnd   = mag_trunc + {{(N-2){1'b0}}, guard & (sticky | mag_trunc[0])};
  assign posit_abs = {1'b0, mag_rnd};
  assign rounded   = stage_i.ops_result.sign ? -posit_abs : posit_abs;

  always_comb begin
    if (stage_i.p_special.is_nar) begin
      posit_o = POSIT_NAR;
    end else if (stage_i.p_special.is_zero || (raw == '0)) begin
      posit_o = POSIT_ZERO;
    end else begin
      posit_o = rounded;
    end
  end

endmodule : normalization

`default_nettype wire

// ==== pipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeline #(
  parameter int PIPELINE_DEPTH = 1,
  parameter int DATA_WIDTH     = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  stall_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  output logic [DATA_WIDTH-1:0] data_o
);

  if (PIPELINE_DEPTH == 0) begin : g_wire
    assign data_o = data_i;  // no stage, straight through
  end else begin : g_regs
    logic [DATA_WIDTH-1:0] regs_q [PIPELINE_DEPTH];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        for (int i = 0; i < PIPELINE_DEPTH; i++) begin
          regs_q[i] <= '0;
        end
      end else if (!stall_i) begin
        regs_q[0] <= data_i;
        // shift the rest of the chain
        for (int i = 1; i < PIPELINE_DEPTH; i++) begin
          regs_q[i] <= regs_q[i-1];
        end
      end
    end

    assign data_o = regs_q[PIPELINE_DEPTH-1];
  end

endmodule : pipeline

`default_nettype wire

// ==== ppu_core_ops.sv ====
`timescale 1ns/1ns
`default_nettype none

module ppu_core_ops
  import ppu_pkg::*;
#(
  parameter int PIPELINE_DEPTH = 1   // registers per stage
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       stall_i,        // holds every stage
  input  operation_e op_i,
  input  posit_t     p1_i,
  input  posit_t     p2_i,
  input  posit_t     p3_i,
  output operation_e op_o,
  output posit_t     pout_o
);

  stage0_t     st0_d, st0_q;
  stage1_t     st1_d, st1_q;
  stage2_t     st2_d, st2_q;
  ops_result_t ops_result;

  // ##############################
  // stage 0: operands in
  // ##############################
  assign st0_d = '{op: op_i, p1: p1_i, p2: p2_i, p3: p3_i};

  pipeline #(
    .PIPELINE_DEPTH (PIPELINE_DEPTH),
    .DATA_WIDTH     ($bits(stage0_t))
  ) pipeline_st0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .data_i  (st0_d),
    .data_o  (st0_q)
  );

  extraction extraction_inst (
    .stage_i (st0_q),
    .stage_o (st1_d)
  );

  // ##############################
  // stage 1: FIR arithmetic
  // ##############################
  pipeline #(
    .PIPELINE_DEPTH (PIPELINE_DEPTH),
    .DATA_WIDTH     ($bits(stage1_t))
  ) pipeline_st1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .data_i  (st1_d),
    .data_o  (st1_q)
  );

  fir_ops fir_ops_inst (
    .op_i     (st1_q.op),
    .fir1_i   (st1_q.fir1),
    .fir2_i   (st1_q.fir2),
    .fir3_i   (st1_q.fir3),
    .result_o (ops_result)
  );

  assign st2_d = '{op: st1_q.op, ops_result: ops_result, p_special: st1_q.p_special};

  // ##############################
  // stage 2: round and pack
  // ##############################
  pipeline #(
    .PIPELINE_DEPTH (PIPELINE_DEPTH),
    .DATA_WIDTH     ($bits(stage2_t))
  ) pipeline_st2 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .data_i  (st2_d),
    .data_o  (st2_q)
  );

  normalization normalization_inst (
    .stage_i (st2_q),
    .posit_o (pout_o)
  );

  assign op_o = st2_q.op;  // opcode leaves with its result

endmodule : ppu_core_ops

`default_nettype wire

// ==== ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

  // ##############################
  // posit format
  // ##############################
  localparam int N         = 16;
  localparam int ES        = 1;
  localparam int TE_BITS   = 6;              // signed, regime * 2^ES + exponent
  localparam int MANT_SIZE = 14;             // hidden bit included
  localparam int RES_MANT  = 2 * MANT_SIZE;  // two integer bits + fraction

  typedef logic [N-1:0] posit_t;

  localparam posit_t POSIT_ZERO = '0;
  localparam posit_t POSIT_NAR  = {1'b1, {(N-1){1'b0}}};

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } operation_e;

  // ##############################
  // fields-in-register forms
  // ##############################
  typedef struct packed {
    logic                      sign;
    logic signed [TE_BITS-1:0] total_exp;
    logic [MANT_SIZE-1:0]      mant;       // 1.13, hidden bit on top
  } fir_t;

  typedef struct packed {
    logic is_zero;
    logic is_nar;
  } posit_special_t;

  // raw arithmetic result, not yet normalized
  typedef struct packed {
    logic                    sign;
    logic signed [TE_BITS:0] total_exp;
    logic [RES_MANT-1:0]     mant;         // 2.26
    logic                    guard;
    logic                    sticky;
  } ops_result_t;

  // ##############################
  // pipeline bundles
  // ##############################
  typedef struct packed {
    operation_e op;
    posit_t     p1;
    posit_t     p2;
    posit_t     p3;
  } stage0_t;

  typedef struct packed {
    operation_e     op;
    fir_t           fir1;
    fir_t           fir2;
    fir_t           fir3;
    posit_special_t p_special;
  } stage1_t;

  typedef struct packed {
    operation_e     op;
    ops_result_t    ops_result;
    posit_special_t p_special;
  } stage2_t;

endpackage : ppu_pkg

`default_nettype wire

// ==== sources.f ====
ppu_pkg.sv
pipeline.sv
extraction.sv
fir_ops.sv
normalization.sv
ppu_core_ops.sv
tb_clock_gen.sv
tb_ppu_core_ops.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;  // released on a rising edge
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== tb_ppu_core_ops.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ppu_core_ops
  import ppu_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int N_KNOWN    = 4;
  localparam int N_SPECIAL  = 20;   // rounds, five rules each
  localparam int N_PAIRS    = 200;  // six ops per pair
  localparam int N_STREAM   = 100;
  localparam int N_STALLED  = 100;
  localparam int TOTAL_OPS  = N_KNOWN + 5 * N_SPECIAL + 6 * N_PAIRS + N_STREAM + N_STALLED;
  localparam longint WATCHDOG_NS = longint'(2 * TOTAL_OPS + 100) * CLK_PERIOD;

  localparam logic [1:0] M_EXACT = 2'd0;
  localparam logic [1:0] M_STORE = 2'd1;  // keep result for the partner op
  localparam logic [1:0] M_SAME  = 2'd2;
  localparam logic [1:0] M_NEG   = 2'd3;

  localparam posit_t HALF = 16'h3000;
  localparam posit_t ONE  = 16'h4000;
  localparam posit_t ONE5 = 16'h4800;
  localparam posit_t TWO  = 16'h5000;
  localparam posit_t FOUR = 16'h6000;

  typedef struct packed {
    operation_e op;
    logic [1:0] mode;
    posit_t     expv;
  } expect_t;

  logic       clk;
  logic       rst_n;
  logic       stall;
  operation_e op_in;
  operation_e op_out;
  posit_t     p1, p2, p3;
  posit_t     pout;

  logic        in_valid;
  expect_t     in_entry;
  expect_t     exp_q[$];
  logic [2:0]  vld = '0;       // model of the three stages
  logic        adv = 1'b1;     // last edge moved the pipeline
  posit_t      last_pout;
  operation_e  last_op;
  posit_t      stored;
  int          check_cnt = 0;
  int          err_cnt = 0;
  int          mark_checks = 0;
  int          mark_errs = 0;
  logic [31:0] lcg_state = 32'h261cc24a;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ppu_core_ops #(.PIPELINE_DEPTH(1)) UUT (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .stall_i (stall),
    .op_i    (op_in),
    .p1_i    (p1),
    .p2_i    (p2),
    .p3_i    (p3),
    .op_o    (op_out),
    .pout_o  (pout)
  );

  // ##############################
  // random numbers and posit rules
  // ##############################
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic posit_t random_posit();
    logic [31:0] r;
    r = lcg_next();
    return r[31:16];  // high bits, better period
  endfunction

  function automatic posit_t random_real_posit();
    posit_t x;
    x = random_posit();
    while (x == POSIT_ZERO || x == POSIT_NAR) begin
      x = random_posit();
    end
    return x;
  endfunction

  function automatic operation_e random_op();
    logic [31:0] r;
    r = lcg_next();
    return operation_e'(2'(r % 32'd3));
  endfunction

  function automatic posit_t negate(input posit_t x);
    return -x;  // posit negation is two's complement
  endfunction

  // ##############################
  // checking
  // ##############################
  task automatic check_result(input expect_t e);
    posit_t want;
    want = e.expv;
    case (e.mode)
      M_STORE: stored = pout;
      M_SAME:  want = stored;
      M_NEG:   want = negate(stored);
      default: want = e.expv;
    endcase
    check_cnt++;
    assert (op_out == e.op) else begin
      err_cnt++;
      $display("Fail %0t: opcode %s, expected %s", $time, op_out.name(), e.op.name());
    end
    if (e.mode != M_STORE) begin
      check_cnt++;
      assert (pout == want) else begin
        err_cnt++;
        $display("Fail %0t: %s result %h, expected %h", $time, e.op.name(), pout, want);
      end
    end
  endtask

  // outputs settle after the rising edge, so look at them half a cycle later
  always @(negedge clk) begin
    expect_t e;
    if (rst_n) begin
      if (adv && vld[2]) begin
        e = exp_q.pop_front();
        check_result(e);
      end else if (adv) begin
        check_cnt++;
        assert (pout == POSIT_ZERO && op_out == OP_ADD) else begin
          err_cnt++;
          $display("Fail %0t: empty slot shows %h op %s", $time, pout, op_out.name());
        end
      end else begin
        check_cnt++;
        assert (pout == last_pout && op_out == last_op) else begin
          err_cnt++;
          $display("Fail %0t: output moved during stall, %h -> %h", $time, last_pout, pout);
        end
      end
      last_pout = pout;
      last_op   = op_out;
      // what the coming edge will do
      adv = !stall;
      if (!stall) begin
        if (in_valid) exp_q.push_back(in_entry);
        vld = {vld[1:0], in_valid};
      end
    end
  end

  // ##############################
  // stimulus
  // ##############################
  task automatic drive_idle();
    @(posedge clk);
    stall    <= 1'b0;
    in_valid <= 1'b0;
    op_in    <= OP_ADD;
    p1       <= POSIT_ZERO;
    p2       <= POSIT_ZERO;
    p3       <= POSIT_ZERO;
  endtask

  task automatic send(input operation_e opc, input posit_t a, input posit_t b,
                      input logic [1:0] mode, input posit_t expv, input bit with_stall);
    logic hold;
    do begin
      hold = with_stall && (lcg_next() % 4 == 0);
      @(posedge clk);
      stall    <= hold;
      in_valid <= !hold;
      in_entry <= '{op: opc, mode: mode, expv: expv};
      if (hold) begin  // junk that must be ignored
        op_in <= random_op();
        p1    <= random_posit();
        p2    <= random_posit();
      end else begin
        op_in <= opc;
        p1    <= a;
        p2    <= b;
      end
      p3 <= random_posit();
    end while (hold);
  endtask

  // result equals x by rule, or zero for x - x
  task automatic send_identity(input bit with_stall);
    posit_t      x;
    logic [31:0] r;
    x = random_real_posit();
    r = lcg_next();
    case (r % 5)
      0: send(OP_ADD, x, POSIT_ZERO, M_EXACT, x, with_stall);
      1: send(OP_SUB, x, POSIT_ZERO, M_EXACT, x, with_stall);
      2: send(OP_MUL, x, ONE, M_EXACT, x, with_stall);
      3: send(OP_MUL, ONE, x, M_EXACT, x, with_stall);
      default: send(OP_SUB, x, x, M_EXACT, POSIT_ZERO, with_stall);
    endcase
  endtask

  task automatic finish_test(input string name);
    do drive_idle(); while (exp_q.size() != 0);
    $display("test %s done: %0d checks, %0d errors", name,
             check_cnt - mark_checks, err_cnt - mark_errs);
    mark_checks = check_cnt;
    mark_errs   = err_cnt;
  endtask

  initial begin
    posit_t a, b;
    stall    = 1'b0;
    in_valid = 1'b0;
    in_entry = '0;
    op_in    = OP_ADD;
    p1       = POSIT_ZERO;
    p2       = POSIT_ZERO;
    p3       = POSIT_ZERO;
    @(posedge rst_n);
    repeat (4) drive_idle();
    finish_test("reset");

    send(OP_ADD, ONE, ONE, M_EXACT, TWO, 1'b0);
    send(OP_MUL, TWO, TWO, M_EXACT, FOUR, 1'b0);
    send(OP_SUB, TWO, HALF, M_EXACT, ONE5, 1'b0);
    send(OP_MUL, HALF, TWO, M_EXACT, ONE, 1'b0);
    finish_test("known");

    for (int i = 0; i < N_SPECIAL; i++) begin
      a = random_real_posit();
      b = random_posit();
      if (i % 2 == 0) begin
        send(random_op(), POSIT_NAR, b, M_EXACT, POSIT_NAR, 1'b0);
        send(OP_MUL, a, POSIT_ZERO, M_EXACT, POSIT_ZERO, 1'b0);
      end else begin
        send(random_op(), b, POSIT_NAR, M_EXACT, POSIT_NAR, 1'b0);
        send(OP_MUL, POSIT_ZERO, a, M_EXACT, POSIT_ZERO, 1'b0);
      end
      send(OP_ADD, a, negate(a), M_EXACT, POSIT_ZERO, 1'b0);
      send(OP_MUL, a, ONE, M_EXACT, a, 1'b0);
      send(OP_ADD, a, POSIT_ZERO, M_EXACT, a, 1'b0);
    end
    finish_test("special");

    for (int i = 0; i < N_PAIRS; i++) begin
      a = random_posit();
      b = random_posit();
      send(OP_ADD, a, b, M_STORE, POSIT_ZERO, 1'b0);
      send(OP_ADD, b, a, M_SAME, POSIT_ZERO, 1'b0);
      send(OP_MUL, a, b, M_STORE, POSIT_ZERO, 1'b0);
      send(OP_MUL, b, a, M_SAME, POSIT_ZERO, 1'b0);
      send(OP_SUB, a, b, M_STORE, POSIT_ZERO, 1'b0);
      send(OP_SUB, b, a, M_NEG, POSIT_ZERO, 1'b0);
    end
    finish_test("symmetry");

    repeat (N_STREAM) send_identity(1'b0);
    finish_test("stream");

    repeat (N_STALLED) send_identity(1'b1);
    finish_test("stall");

    $display("total: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns, stopping", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule : tb_ppu_core_ops

`default_nettype wire
